// ==== fetch_front.f ====
verilog/cpu_pkg.sv
verilog/btb.sv
verilog/addr_trans.sv
verilog/fetch1.sv
verilog/fetch_front.sv
tests/fetch_front_assertions.sv
tests/fetch_front_tb.sv

// ==== tests/fetch_front_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_front_tb;
    import cpu_pkg::*;

    localparam u32_t RESET_PC        = 32'h1c00_0000;
    localparam int   BTB_ENTRIES     = 16;
    localparam int   IDX_W           = $clog2(BTB_ENTRIES);
    localparam int   RAND_CYCLES     = 1400;
    localparam int   DIRECTED_CYCLES = 100;     // reset, sequential, btb and stall steps
    localparam int   TIMEOUT_CYCLES  = 2 * (RAND_CYCLES + DIRECTED_CYCLES);
    localparam u32_t BR_PC           = 32'h1c00_0100;   // trained branch
    localparam u32_t BR_TGT          = 32'h1c00_0400;

    logic                  clk;
    logic                  rst_n;
    logic                  excp_redir_valid;
    u32_t                  excp_redir_pc;
    logic                  ex_redir_valid;
    u32_t                  ex_redir_pc;
    logic                  btb_upd_en;
    u32_t                  btb_upd_pc;
    u32_t                  btb_upd_target;
    logic                  crmd_da;
    logic                  crmd_pg;
    plv_t                  crmd_plv;
    mat_t                  crmd_datf;
    dmw_t                  dmw0;
    dmw_t                  dmw1;
    logic [IC_IDX_W-1:0]   icache_idx;
    ic_op_t                icache_op;
    phy_t                  icache_pa;
    logic                  icache_is_cached;
    logic                  icache_busy;
    logic                  flush;
    logic                  next_rdy_in;
    logic                  rdy_in;
    logic                  out_valid;
    u32_t                  out_pc;
    u32_t                  out_btb_pre;
    logic                  excp_valid;
    ecode_t                excp_ecode;
    u32_t                  excp_badv;

    // reference model state
    u32_t   m_pc;                               // mirrors pc_r
    logic   m_valid [BTB_ENTRIES];
    u32_t   m_tag   [BTB_ENTRIES];              // pc >> (IDX_W + 2)
    u32_t   m_tgt   [BTB_ENTRIES];
    logic   m_pv;                               // registered prediction for m_pc
    u32_t   m_pnpc;

    integer seed = 12905;
    int     cycle_cnt;
    int     err_cnt;
    logic   wild_pc;                            // random segment and misaligned targets

    fetch_front #(
        .RESET_PC    (RESET_PC),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) uut (
        .clk(clk), .rst_n(rst_n),
        .excp_redir_valid(excp_redir_valid), .excp_redir_pc(excp_redir_pc),
        .ex_redir_valid(ex_redir_valid), .ex_redir_pc(ex_redir_pc),
        .btb_upd_en(btb_upd_en), .btb_upd_pc(btb_upd_pc), .btb_upd_target(btb_upd_target),
        .crmd_da(crmd_da), .crmd_pg(crmd_pg), .crmd_plv(crmd_plv), .crmd_datf(crmd_datf),
        .dmw0(dmw0), .dmw1(dmw1),
        .icache_idx(icache_idx), .icache_op(icache_op), .icache_pa(icache_pa),
        .icache_is_cached(icache_is_cached), .icache_busy(icache_busy),
        .flush(flush), .next_rdy_in(next_rdy_in), .rdy_in(rdy_in),
        .out_valid(out_valid), .out_pc(out_pc), .out_btb_pre(out_btb_pre),
        .excp_valid(excp_valid), .excp_ecode(excp_ecode), .excp_badv(excp_badv)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 10 ns period
    end

    // expected npc by redirect priority
    function automatic u32_t expected_npc();
        if (excp_redir_valid) return excp_redir_pc;
        if (ex_redir_valid) return ex_redir_pc;
        if (m_pv) return m_pnpc;
        return m_pc + 32'd4;
    endfunction

    function automatic logic win_match(input dmw_t w, input u32_t va);
        logic en;
        en = (crmd_plv == 2'd0) ? w[0] : ((crmd_plv == 2'd3) ? w[3] : 1'b0);
        return en && (w[31:29] == va[31:29]);
    endfunction

    function automatic phy_t expected_pa(input u32_t va);
        if (crmd_da) return va;
        if (win_match(dmw0, va)) return {dmw0[27:25], va[28:0]};
        return {dmw1[27:25], va[28:0]};         // only used when some window hits
    endfunction

    function automatic logic expected_cached(input u32_t va);
        if (crmd_da) return crmd_datf[0];
        if (win_match(dmw0, va)) return dmw0[4];
        return dmw1[4];
    endfunction

    // zero when no exception is expected
    function automatic ecode_t expected_ecode(input u32_t va);
        if (va[1:0] != 2'b00) return ECODE_ADEF;
        if (!crmd_da && !win_match(dmw0, va) && !win_match(dmw1, va)) return ECODE_TLBR;
        return '0;
    endfunction

    task automatic abort_run();
        err_cnt++;
        $display("Verification failed");
        $fatal(1, "run stopped at cycle %0d", cycle_cnt);
    endtask

    task automatic check_u32(input string name, input u32_t got, input u32_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ecode(input string name, input ecode_t got, input ecode_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ic_op(input string name, input ic_op_t got, input ic_op_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // compare on each rising edge, then step the model
    always @(posedge clk) begin : compare
        u32_t   npc;
        ecode_t ec;
        logic   stall;
        int     li;
        if (rst_n) begin
            stall = !next_rdy_in || icache_busy;
            npc   = expected_npc();
            ec    = expected_ecode(m_pc);
            check_u32("out_pc", out_pc, m_pc);
            check_u32("excp_badv", excp_badv, m_pc);
            check_u32("icache_idx", u32_t'(icache_idx), u32_t'(m_pc[IC_IDX_W-1:0]));
            check_u32("out_btb_pre", out_btb_pre, npc);
            check_bit("rdy_in", rdy_in, flush || !stall);
            check_bit("out_valid", out_valid, !flush && !stall);
            check_ic_op("icache_op", icache_op, flush ? IC_NOP : IC_R);
            check_bit("excp_valid", excp_valid, ec != '0);
            if (ec != '0) begin
                check_ecode("excp_ecode", excp_ecode, ec);
            end else begin
                check_u32("icache_pa", icache_pa, expected_pa(m_pc));
                check_bit("icache_is_cached", icache_is_cached, expected_cached(m_pc));
            end
            if (!stall) begin
                li   = npc[IDX_W+1:2];          // lookup sees the table before this write
                m_pv = m_valid[li] && (m_tag[li] == (npc >> (IDX_W + 2)));
                if (m_pv) m_pnpc = m_tgt[li];
            end
            if (btb_upd_en) begin
                li          = btb_upd_pc[IDX_W+1:2];
                m_valid[li] = 1'b1;
                m_tag[li]   = btb_upd_pc >> (IDX_W + 2);
                m_tgt[li]   = btb_upd_target;
            end
            if (flush || !stall) m_pc = npc;
        end else begin
            m_pc = RESET_PC;
            m_pv = 1'b0;
            for (li = 0; li < BTB_ENTRIES; li++) m_valid[li] = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
        if (uut.u_fetch1.u_fetch1_assertions.fail_cnt != 0) begin
            $display("A fetch1 assertion failed in the previous cycle");
            abort_run();
        end
    end

    function automatic u32_t pick_pc();
        u32_t a;
        a = 32'h1c00_0000 | (u32_t'($random(seed)) & 32'h0000_01fc);   // small region, btb hits
        if (wild_pc) begin
            a[31:29] = 3'($random(seed));
            if (($random(seed) & 15) == 0) a[1:0] = 2'b10;
        end
        return a;
    endfunction

    task automatic idle_inputs();
        excp_redir_valid = 1'b0;
        excp_redir_pc    = '0;
        ex_redir_valid   = 1'b0;
        ex_redir_pc      = '0;
        btb_upd_en       = 1'b0;
        btb_upd_pc       = '0;
        btb_upd_target   = '0;
        icache_busy      = 1'b0;
        flush            = 1'b0;
        next_rdy_in      = 1'b1;
    endtask

    task automatic drive_random();
        excp_redir_valid = ($random(seed) & 15) == 0;
        excp_redir_pc    = pick_pc();
        ex_redir_valid   = ($random(seed) & 7) == 0;
        ex_redir_pc      = pick_pc();
        btb_upd_en       = ($random(seed) & 3) == 0;
        btb_upd_pc       = pick_pc();
        btb_upd_target   = pick_pc();
        icache_busy      = ($random(seed) & 7) == 0;
        next_rdy_in      = ($random(seed) & 7) != 0;
        flush            = ($random(seed) & 15) == 0;
    endtask

    task automatic shuffle_csr();
        crmd_da   = 1'($random(seed));
        crmd_pg   = !crmd_da;                   // da and pg kept exclusive
        crmd_plv  = ($random(seed) & 1) ? 2'd3 : 2'd0;
        crmd_datf = 2'($random(seed));
        dmw0      = $random(seed);
        dmw0[31:29] = 3'b000;                   // covers the 0x1c region
        dmw1      = $random(seed);
    endtask

    initial begin
        u32_t held;
        rst_n     = 1'b0;
        idle_inputs();
        crmd_da   = 1'b1;
        crmd_pg   = 1'b0;
        crmd_plv  = 2'd0;
        crmd_datf = 2'b01;
        dmw0      = '0;
        dmw1      = '0;
        wild_pc   = 1'b0;
        cycle_cnt = 0;
        err_cnt   = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        repeat (12) @(negedge clk);             // plain sequential fetch
        check_u32("out_pc", out_pc, RESET_PC + 32'd48);
        btb_upd_en     = 1'b1;
        btb_upd_pc     = BR_PC;
        btb_upd_target = BR_TGT;
        @(negedge clk);
        btb_upd_en     = 1'b0;
        ex_redir_valid = 1'b1;
        ex_redir_pc    = BR_PC;
        @(negedge clk);
        ex_redir_valid = 1'b0;
        @(posedge clk);                         // prediction for the trained pc
        check_u32("out_pc", out_pc, BR_PC);
        check_u32("out_btb_pre", out_btb_pre, BR_TGT);
        @(negedge clk);
        check_u32("out_pc", out_pc, BR_TGT);
        ex_redir_valid = 1'b1;
        ex_redir_pc    = BR_PC ^ 32'h0000_1000; // same index, other tag
        @(negedge clk);
        ex_redir_valid = 1'b0;
        @(posedge clk);
        check_u32("out_btb_pre", out_btb_pre, (BR_PC ^ 32'h0000_1000) + 32'd4);
        @(negedge clk);
        held        = out_pc;
        icache_busy = 1'b1;
        repeat (3) @(negedge clk);
        check_u32("out_pc", out_pc, held);
        check_bit("out_valid", out_valid, 1'b0);
        flush = 1'b1;                           // flush advances even while busy
        @(negedge clk);
        idle_inputs();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            if ((i % 100 == 0) && (i >= 200)) begin
                wild_pc = 1'b1;
                shuffle_csr();
            end
            drive_random();
            @(negedge clk);
        end
        idle_inputs();
        repeat (2) @(negedge clk);
        if (err_cnt == 0 && uut.u_fetch1.u_fetch1_assertions.fail_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "%0d errors", err_cnt + uut.u_fetch1.u_fetch1_assertions.fail_cnt);
        end
    end

endmodule

`default_nettype wire

// ==== tests/fetch_front_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch1_assertions (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rdy_in,
    input  cpu_pkg::u32_t   pc_r,
    input  logic            flush,
    input  cpu_pkg::ic_op_t icache_op,
    input  logic            out_valid
);
    import cpu_pkg::*;

    int fail_cnt = 0;                           // failed assertions so far

    pc_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        !rdy_in |=> $stable(pc_r))              // pc holds while not ready
        else begin
            $error("pc_r changed while rdy_in was low");
            fail_cnt++;
        end

    flush_nop_a: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> (icache_op == IC_NOP))        // no icache read in a flushed slot
        else begin
            $error("icache_op is not IC_NOP during flush");
            fail_cnt++;
        end

    valid_rdy_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> rdy_in)
        else begin
            $error("out_valid high while rdy_in low");
            fail_cnt++;
        end

endmodule

bind fetch1 fetch1_assertions u_fetch1_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdy_in    (rdy_in),
    .pc_r      (pc_r),
    .flush     (flush),
    .icache_op (icache_op),
    .out_valid (out_valid)
);

`default_nettype wire

// ==== verilog/fetch_front.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_front #(
    parameter cpu_pkg::u32_t RESET_PC    = 32'h1c00_0000,
    parameter int            BTB_ENTRIES = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // redirects
    input  logic                          excp_redir_valid,
    input  cpu_pkg::u32_t                 excp_redir_pc,
    input  logic                          ex_redir_valid,
    input  cpu_pkg::u32_t                 ex_redir_pc,
    // btb training
    input  logic                          btb_upd_en,
    input  cpu_pkg::u32_t                 btb_upd_pc,
    input  cpu_pkg::u32_t                 btb_upd_target,
    // csr state
    input  logic                          crmd_da,
    input  logic                          crmd_pg,
    input  cpu_pkg::plv_t                 crmd_plv,
    input  cpu_pkg::mat_t                 crmd_datf,
    input  cpu_pkg::dmw_t                 dmw0,
    input  cpu_pkg::dmw_t                 dmw1,
    // icache
    output logic [cpu_pkg::IC_IDX_W-1:0]  icache_idx,
    output cpu_pkg::ic_op_t               icache_op,
    output cpu_pkg::phy_t                 icache_pa,
    output logic                          icache_is_cached,
    input  logic                          icache_busy,
    // pipeline
    input  logic                          flush,
    input  logic                          next_rdy_in,
    output logic                          rdy_in,
    output logic                          out_valid,
    output cpu_pkg::u32_t                 out_pc,
    output cpu_pkg::u32_t                 out_btb_pre,
    output logic                          excp_valid,
    output cpu_pkg::ecode_t               excp_ecode,
    output cpu_pkg::u32_t                 excp_badv
);
    import cpu_pkg::*;

    u32_t   btb_pc;                         // npc into the btb
    logic   btb_stall;
    logic   pred_valid;
    u32_t   pred_npc;
    u32_t   pc_r;                           // current fetch pc, va for translation
    phy_t   tr_pa;
    mat_t   tr_mat;
    logic   tr_excp_valid;
    ecode_t tr_excp_ecode;

    btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (btb_stall),
        .pc         (btb_pc),
        .upd_en     (btb_upd_en),
        .upd_pc     (btb_upd_pc),
        .upd_target (btb_upd_target),
        .pred_valid (pred_valid),
        .pred_npc   (pred_npc)
    );

    addr_trans u_addr_trans (
        .va         (pc_r),
        .crmd_da    (crmd_da),
        .crmd_pg    (crmd_pg),
        .crmd_plv   (crmd_plv),
        .crmd_datf  (crmd_datf),
        .dmw0       (dmw0),
        .dmw1       (dmw1),
        .pa         (tr_pa),
        .mat        (tr_mat),
        .excp_valid (tr_excp_valid),
        .excp_ecode (tr_excp_ecode)
    );

    fetch1 #(
        .RESET_PC (RESET_PC)
    ) u_fetch1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .excp_redir_valid (excp_redir_valid),
        .excp_redir_pc    (excp_redir_pc),
        .ex_redir_valid   (ex_redir_valid),
        .ex_redir_pc      (ex_redir_pc),
        .pred_valid       (pred_valid),
        .pred_npc         (pred_npc),
        .btb_pc           (btb_pc),
        .btb_stall        (btb_stall),
        .pc_r             (pc_r),
        .pa               (tr_pa),
        .mat              (tr_mat),
        .tr_excp_valid    (tr_excp_valid),
        .tr_excp_ecode    (tr_excp_ecode),
        .icache_idx       (icache_idx),
        .icache_op        (icache_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .icache_busy      (icache_busy),
        .flush            (flush),
        .next_rdy_in      (next_rdy_in),
        .rdy_in           (rdy_in),
        .out_valid        (out_valid),
        .out_pc           (out_pc),
        .out_btb_pre      (out_btb_pre),
        .excp_valid       (excp_valid),
        .excp_ecode       (excp_ecode),
        .excp_badv        (excp_badv)
    );

endmodule

`default_nettype wire

// ==== verilog/fetch1.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch1 #(
    parameter cpu_pkg::u32_t RESET_PC = 32'h1c00_0000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // redirects
    input  logic                          excp_redir_valid,  // from writeback
    input  cpu_pkg::u32_t                 excp_redir_pc,
    input  logic                          ex_redir_valid,    // from execute
    input  cpu_pkg::u32_t                 ex_redir_pc,
    // btb
    input  logic                          pred_valid,        // refers to current pc_r
    input  cpu_pkg::u32_t                 pred_npc,
    output cpu_pkg::u32_t                 btb_pc,
    output logic                          btb_stall,
    // translation
    output cpu_pkg::u32_t                 pc_r,
    input  cpu_pkg::phy_t                 pa,
    input  cpu_pkg::mat_t                 mat,
    input  logic                          tr_excp_valid,
    input  cpu_pkg::ecode_t               tr_excp_ecode,
    // icache
    output logic [cpu_pkg::IC_IDX_W-1:0]  icache_idx,
    output cpu_pkg::ic_op_t               icache_op,
    output cpu_pkg::phy_t                 icache_pa,
    output logic                          icache_is_cached,
    input  logic                          icache_busy,
    // pipeline control
    input  logic                          flush,
    input  logic                          next_rdy_in,
    output logic                          rdy_in,
    // stage outputs
    output logic                          out_valid,
    output cpu_pkg::u32_t                 out_pc,
    output cpu_pkg::u32_t                 out_btb_pre,
    output logic                          excp_valid,
    output cpu_pkg::ecode_t               excp_ecode,
    output cpu_pkg::u32_t                 excp_badv
);
    import cpu_pkg::*;

    logic stall;                            // downstream or icache not ready
    u32_t npc;

    // flush overrides stall so the pipe can drain
    assign stall     = ~next_rdy_in | icache_busy;
    assign rdy_in    = flush | ~stall;
    assign out_valid = ~flush & ~stall;     // flushed slot is never valid

    // next pc, highest priority first
    always_comb begin
        if (excp_redir_valid) begin
            npc = excp_redir_pc;
        end else if (ex_redir_valid) begin
            npc = ex_redir_pc;
        end else if (pred_valid) begin
            npc = pred_npc;                 // prediction looked up with this pc
        end else begin
            npc = pc_r + u32_t'(PC_STEP);
        end
    end

    // pc register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_r <= RESET_PC;
        end else if (rdy_in) begin
            pc_r <= npc;
        end
    end

    // btb gets npc one cycle ahead, so its result lines up with pc_r
    assign btb_pc    = npc;
    assign btb_stall = stall;               // btb output holds with pc_r

    // icache request
    assign icache_idx       = pc_r[IC_IDX_W-1:0];   // virtually indexed
    assign icache_op        = flush ? IC_NOP : IC_R;
    assign icache_pa        = pa;
    assign icache_is_cached = mat[0];

    // stage outputs
    assign out_pc      = pc_r;
    assign out_btb_pre = npc;               // predicted pc of the next fetch

    // exception info goes down regardless of flush
    assign excp_valid = tr_excp_valid;
    assign excp_ecode = tr_excp_ecode;
    assign excp_badv  = pc_r;

endmodule

`default_nettype wire

// ==== verilog/addr_trans.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_trans (
    input  cpu_pkg::u32_t   va,             // fetch virtual address
    input  logic            crmd_da,        // direct-address enable
    input  logic            crmd_pg,        // paging enable
    input  cpu_pkg::plv_t   crmd_plv,
    input  cpu_pkg::mat_t   crmd_datf,      // fetch mat in direct mode
    input  cpu_pkg::dmw_t   dmw0,
    input  cpu_pkg::dmw_t   dmw1,
    output cpu_pkg::phy_t   pa,
    output cpu_pkg::mat_t   mat,
    output logic            excp_valid,
    output cpu_pkg::ecode_t excp_ecode
);
    import cpu_pkg::*;

    // window match: vseg compare plus the enable for the current plv
    function automatic logic dmw_hit(input dmw_t dmw, input u32_t addr, input plv_t plv);
        logic plv_ok;
        logic seg_ok;
        plv_ok = ((plv == PLV0) && dmw[DMW_PLV0]) ||
                 ((plv == PLV3) && dmw[DMW_PLV3]);  // plv1/2 never enabled
        seg_ok = (seg_t'(dmw[DMW_VSEG_HI:DMW_VSEG_LO]) ==
                  seg_t'(addr[DMW_VSEG_HI:DMW_VSEG_LO]));
        return plv_ok && seg_ok;
    endfunction

    // remapped address: window pseg on top of the va offset
    function automatic phy_t dmw_pa(input dmw_t dmw, input u32_t addr);
        phy_t res;
        res = {dmw[DMW_PSEG_HI:DMW_PSEG_LO], addr[DMW_VSEG_LO-1:0]};
        return res;
    endfunction

    logic direct_mode;                      // pa = va
    logic hit0;
    logic hit1;
    logic win_hit;                          // any window matched
    logic misalign;
    phy_t map_pa;
    mat_t map_mat;

    // da set, or paging off, counts as direct translation
    assign direct_mode = crmd_da | ~crmd_pg;

    assign hit0    = dmw_hit(dmw0, va, crmd_plv);
    assign hit1    = dmw_hit(dmw1, va, crmd_plv);
    assign win_hit = hit0 | hit1;

    assign misalign = (va[1:0] != 2'b00);   // fetch is word sized

    // window select, dmw0 has priority
    always_comb begin
        if (hit0) begin
            map_pa  = dmw_pa(dmw0, va);
            map_mat = dmw0[DMW_MAT_HI:DMW_MAT_LO];
        end else if (hit1) begin
            map_pa  = dmw_pa(dmw1, va);
            map_mat = dmw1[DMW_MAT_HI:DMW_MAT_LO];
        end else begin
            map_pa  = va;                   // no lookup without tlb
            map_mat = MAT_SUC;              // keep a missed fetch uncached
        end
    end

    // mode select
    always_comb begin
        if (direct_mode) begin
            pa  = va;
            mat = crmd_datf;
        end else begin
            pa  = map_pa;
            mat = map_mat;
        end
    end

    // fetch exceptions, adef outranks tlbr
    always_comb begin
        if (misalign) begin
            excp_valid = 1'b1;
            excp_ecode = ECODE_ADEF;
        end else if (!direct_mode && !win_hit) begin
            excp_valid = 1'b1;
            excp_ecode = ECODE_TLBR;        // would be a tlb refill
        end else begin
            excp_valid = 1'b0;
            excp_ecode = ECODE_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/btb.sv ====
`timescale 1ns/100ps
`default_nettype none

module btb #(
    parameter int BTB_ENTRIES = 16          // power of two, at least 2
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,            // hold the prediction register
    input  cpu_pkg::u32_t pc,               // lookup address (fetch npc)
    input  logic          upd_en,           // training write from execute
    input  cpu_pkg::u32_t upd_pc,
    input  cpu_pkg::u32_t upd_target,
    output logic          pred_valid,       // hit for the pc looked up last
    output cpu_pkg::u32_t pred_npc
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;      // pc bits above the index

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    // entry storage
    logic [BTB_ENTRIES-1:0] valid_q;        // per-entry valid bit
    btb_tag_t               tag_q [BTB_ENTRIES];
    u32_t                   target_q [BTB_ENTRIES];

    // address split
    btb_idx_t lk_idx;
    btb_tag_t lk_tag;
    btb_idx_t up_idx;
    btb_tag_t up_tag;

    logic lk_hit;                           // combinational hit before the register
    logic pred_valid_q;
    u32_t pred_npc_q;

    assign lk_idx = pc[IDX_W+1:2];          // word aligned, skip bits 1:0
    assign lk_tag = pc[31:IDX_W+2];
    assign up_idx = upd_pc[IDX_W+1:2];
    assign up_tag = upd_pc[31:IDX_W+2];

    assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    // valid bits, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[up_idx] <= 1'b1;        // train marks the entry live
        end
    end

    // tag and target payload
    always_ff @(posedge clk) begin
        if (upd_en) begin
            tag_q[up_idx]    <= up_tag;
            target_q[up_idx] <= upd_target;
        end
    end

    // registered lookup, read sees the array before this edge's write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid_q <= 1'b0;
        end else if (!stall) begin
            pred_valid_q <= lk_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pred_npc_q <= target_q[lk_idx]; // only meaningful with pred_valid
        end
    end

    assign pred_valid = pred_valid_q;
    assign pred_npc   = pred_npc_q;

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // basic word types
    typedef logic [31:0] u32_t;             // va, pc, badv
    typedef logic [31:0] phy_t;             // physical address
    typedef logic [1:0]  mat_t;             // memory access type, bit 0 set = cached
    typedef logic [14:0] ecode_t;           // {esubcode[8:0], ecode[5:0]}
    typedef logic [1:0]  plv_t;             // privilege level
    typedef logic [31:0] dmw_t;             // direct-mapped window csr image

    // icache request codes
    typedef enum logic [2:0] {
        IC_NOP = 3'd0,                      // no access this cycle
        IC_R   = 3'd1                       // instruction read
    } ic_op_t;

    localparam int IC_IDX_W = 12;           // icache index taken from the va
    localparam int PC_STEP  = 4;            // sequential fetch increment

    // exception codes seen by the fetch stage
    localparam ecode_t ECODE_NONE = 15'h000;
    localparam ecode_t ECODE_ADEF = 15'h008; // fetch address error
    localparam ecode_t ECODE_TLBR = 15'h03f; // tlb refill

    // privilege levels that own a window enable bit
    localparam plv_t PLV0 = 2'd0;
    localparam plv_t PLV3 = 2'd3;

    // mat used when no window supplies one
    localparam mat_t MAT_SUC = 2'd0;        // strongly-ordered uncached

    // dmw field positions
    localparam int DMW_PLV0    = 0;         // window usable at plv0
    localparam int DMW_PLV3    = 3;         // window usable at plv3
    localparam int DMW_MAT_LO  = 4;
    localparam int DMW_MAT_HI  = 5;
    localparam int DMW_PSEG_LO = 25;
    localparam int DMW_PSEG_HI = 27;
    localparam int DMW_VSEG_LO = 29;
    localparam int DMW_VSEG_HI = 31;

    // segment number selected by a window, 3 msbs of the address
    typedef logic [DMW_VSEG_HI-DMW_VSEG_LO:0] seg_t;

endpackage

`default_nettype wire
